/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_exec_stage
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   := $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
+incdir+verilog
verilog/exec_isa_pkg.sv
verilog/exec_if_pkg.sv
verilog/exec_alu.sv
verilog/exec_branch.sv
verilog/exec_lsu.sv
verilog/exec_csr.sv
verilog/exec_trap.sv
verilog/exec_retire.sv
verilog/exec_stage.sv
tests/tb_exec_stage.sv

/* tests/tb_exec_stage.sv */
`timescale 1ns/1ps

`include "exec_params.svh"

module tb_exec_stage
    import exec_isa_pkg::*;
    import exec_if_pkg::*;
();

    localparam int WAIT_LIMIT = 50;

    logic             clk;
    logic             reset_n;
    issue_t           issue;
    priv_e            privilege;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mepc;
    logic [`XLEN-1:0] csr_rdata;
    logic             credit_return;
    logic             issue_ready;
    csr_req_t         csr_req;
    mem_req_t         mem_req;
    retire_t          retire;
    redirect_t        redirect;

    // Expected values for the instruction on issue
    retire_t                  exp_retire;
    mem_req_t                 exp_mem;
    csr_req_t                 exp_csr;
    redirect_t                exp_redirect;
    logic [`CREDIT_CNT_W-1:0] model_credits;
    logic                     accept;
    int                       seed = 32'h632f_1ffe;

    op_e alu_ops[12]   = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, LUI, AUIPC};
    op_e branch_ops[6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
    op_e mem_ops[8]    = '{LB, LBU, LH, LHU, LW, SB, SH, SW};
    op_e csr_ops[6]    = '{CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI};

    // Equal, signed-less only, unsigned-less only
    logic [`XLEN-1:0] pair_a[3] = '{32'd7, 32'hffff_fff0, 32'd5};
    logic [`XLEN-1:0] pair_b[3] = '{32'd7, 32'd5, 32'h8000_0000};

    exec_stage exec_stage_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .issue_i         (issue),
        .issue_ready_o   (issue_ready),
        .privilege_i     (privilege),
        .mtvec_i         (mtvec),
        .mepc_i          (mepc),
        .csr_rdata_i     (csr_rdata),
        .csr_req_o       (csr_req),
        .credit_return_i (credit_return),
        .mem_req_o       (mem_req),
        .retire_o        (retire),
        .redirect_o      (redirect)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    assign accept = issue.valid && (model_credits != '0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            model_credits <= `EXEC_CREDITS;
        else if (accept && !credit_return)
            model_credits <= model_credits - 1'b1;
        else if (credit_return && !accept)
            model_credits <= model_credits + 1'b1;
    end

    task automatic model_issue(input issue_t it);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] sum;
        logic [`XLEN-1:0] target;
        logic [`XLEN-1:0] result;
        logic [1:0]       off;
        int               size;
        logic             taken;
        logic             is_load;
        logic             is_store;
        logic             mis;
        logic             is_csr;
        logic             rd_en;
        logic             wr_en;
        logic             illegal;
        logic             raise;
        exc_code_e        code;

        a   = it.rs1_data;
        b   = it.operand_b;
        sum = (it.op == SUB) ? a - b : a + b;
        off = sum[1:0];

        case (it.op)
            BEQ:       taken = (a == b);
            BNE:       taken = (a != b);
            BLT:       taken = ($signed(a) < $signed(b));
            BGE:       taken = ($signed(a) >= $signed(b));
            BLTU:      taken = (a < b);
            BGEU:      taken = (a >= b);
            JAL, JALR: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
        target = (it.op == JALR) ? (sum & ~32'd1) : it.imm_target;

        // Memory side
        is_load  = it.op inside {LB, LBU, LH, LHU, LW};
        is_store = it.op inside {SB, SH, SW};
        size     = (it.op inside {LB, LBU, SB}) ? 1 : (it.op inside {LH, LHU, SH}) ? 2 : 4;
        mis      = (size == 2 && off[0]) || (size == 4 && off != 2'b00);
        exp_mem       = '0;
        exp_mem.addr  = sum;
        exp_mem.read  = is_load;
        exp_mem.wdata = it.rs2_data;
        for (int lane = 0; lane < `BYTE_LANES; lane++) begin
            if (is_store && lane >= off && lane < off + size)
                exp_mem.byte_en[lane] = 1'b1;
        end
        if (it.op == SB)
            exp_mem.wdata = {4{it.rs2_data[7:0]}};
        if (it.op == SH)
            exp_mem.wdata = {2{it.rs2_data[15:0]}};

        // CSR side
        is_csr  = it.op inside {CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI};
        rd_en   = is_csr && !((it.op inside {CSRRW, CSRRWI}) && it.rd == '0);
        wr_en   = is_csr && ((it.op inside {CSRRW, CSRRWI}) || it.rs1 != '0);
        illegal = (wr_en && it.csr_addr[11:10] == 2'b11) ||
                  (is_csr && it.csr_addr[9:8] > privilege);
        exp_csr = '0;
        if (is_csr) begin
            exp_csr.read  = rd_en && !illegal;
            exp_csr.write = wr_en && !illegal;
            if (it.op inside {CSRRW, CSRRWI})
                exp_csr.op = WRITE;
            else if (it.op inside {CSRRS, CSRRSI})
                exp_csr.op = SET;
            else
                exp_csr.op = CLEAR;
            exp_csr.wdata = (it.op inside {CSRRWI, CSRRSI, CSRRCI}) ? `XLEN'(it.rs1)
                                                                     : it.rs1_data;
        end

        // Trap causes in priority order
        code = NE;
        if (illegal)
            code = ILLEGAL_INSTR;
        else if (taken && target[1])
            code = INSTR_ADDR_MISALIGNED;
        else if (it.op == ECALL && privilege == USER)
            code = ECALL_FROM_UMODE;
        else if (it.op == ECALL)
            code = ECALL_FROM_MMODE;
        else if (it.op == EBREAK)
            code = BREAKPOINT;
        else if (is_load && mis)
            code = LOAD_ADDR_MISALIGNED;
        else if (is_store && mis)
            code = STORE_ADDR_MISALIGNED;
        raise = (code != NE);

        exp_redirect                 = '0;
        exp_redirect.raise_exception = raise;
        exp_redirect.exception_code  = code;
        exp_redirect.mret            = (it.op == MRET) && !raise;
        exp_redirect.ctx_switch      = raise || exp_redirect.mret;
        exp_redirect.jump            = taken && !raise;
        if (raise)
            exp_redirect.target = mtvec;
        else if (exp_redirect.mret)
            exp_redirect.target = mepc;
        else if (taken)
            exp_redirect.target = target;

        case (it.op)
            CSRRW, CSRRS, CSRRC,
            CSRRWI, CSRRSI, CSRRCI: result = csr_rdata;
            JAL, JALR:              result = it.pc_next;
            LUI:                    result = b;
            AUIPC:                  result = it.imm_target;
            SLT:                    result = {31'd0, $signed(a) < $signed(b)};
            SLTU:                   result = {31'd0, a < b};
            AND:                    result = a & b;
            OR:                     result = a | b;
            XOR:                    result = a ^ b;
            SLL:                    result = a << b[4:0];
            SRL:                    result = a >> b[4:0];
            SRA:                    result = $signed(a) >>> b[4:0];
            default:                result = sum;
        endcase
        exp_retire.valid  = 1'b1;
        exp_retire.op     = it.op;
        exp_retire.rd     = it.rd;
        exp_retire.result = result;
        exp_retire.we     = (it.rd != '0) && !raise &&
            !(it.op inside {NOP, SB, SH, SW, BEQ, BNE, BLT, BGE, BLTU, BGEU});
        exp_mem.valid     = (is_load || is_store) && !raise;
    endtask

    //////////////////////////////
    // Checks
    //////////////////////////////

    assert property (@(posedge clk) disable iff (!reset_n)
        issue_ready == (model_credits != '0))
        else fail_run($sformatf("error: %0t: issue_ready_o is %0b", $time, issue_ready));

    assert property (@(posedge clk) disable iff (!reset_n)
        accept |-> (redirect == exp_redirect) && (csr_req == exp_csr))
        else fail_run($sformatf("error: %0t: redirect_o %h csr_req_o %h",
                                $time, redirect, csr_req));

    assert property (@(posedge clk) disable iff (!reset_n)
        !accept |-> (redirect == '0) && (csr_req == '0))
        else fail_run($sformatf("error: %0t: idle redirect_o %h csr_req_o %h",
                                $time, redirect, csr_req));

    assert property (@(posedge clk) disable iff (!reset_n)
        $past(accept) |-> (retire == $past(exp_retire)))
        else fail_run($sformatf("error: %0t: retire_o %h", $time, retire));

    assert property (@(posedge clk) disable iff (!reset_n)
        $past(accept) |-> ($past(exp_mem.valid) ? (mem_req == $past(exp_mem))
                                                : !mem_req.valid))
        else fail_run($sformatf("error: %0t: mem_req_o %h", $time, mem_req));

    assert property (@(posedge clk) disable iff (!reset_n)
        !$past(accept) |-> !retire.valid && !mem_req.valid)
        else fail_run($sformatf("error: %0t: valid without accept", $time));

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic make_issue(input op_e op, output issue_t it);
        it            = '0;
        it.valid      = 1'b1;
        it.op         = op;
        it.rs1_data   = $random(seed);
        it.rs2_data   = $random(seed);
        it.operand_b  = $random(seed);
        it.rd         = $random(seed);
        it.rs1        = $random(seed);
        it.csr_addr   = 12'h300;   // mstatus
        it.pc_next    = $random(seed) & 32'hffff_fffc;
        it.imm_target = $random(seed) & 32'hffff_fffc;
    endtask

    task automatic present(input issue_t it);
        csr_rdata = $random(seed);
        issue     = it;
        model_issue(it);
    endtask

    // One instruction, then its credit comes back
    task automatic send(input issue_t it);
        int waited;

        waited = 0;
        present(it);
        while (!issue_ready) begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT)
                fail_run("timeout while waiting for issue_ready_o");
        end
        next_cycle();
        issue.valid   = 1'b0;
        credit_return = 1'b1;
        next_cycle();
        credit_return = 1'b0;
    endtask

    initial begin
        issue_t it;
        int     idx;
        int     accepts;
        logic   was_ready;

        issue         = '0;
        privilege     = MACHINE;
        mtvec         = 32'h0000_0400;
        mepc          = 32'h0000_2a40;
        csr_rdata     = '0;
        credit_return = 1'b0;
        reset_n       = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        reset_n = 1'b1;
        next_cycle();

        for (int i = 0; i < 48; i++) begin
            idx = $unsigned($random(seed)) % 12;
            make_issue(alu_ops[idx], it);
            if (i % 6 == 0)
                it.rd = '0;   // Write enable must drop
            send(it);
        end

        foreach (branch_ops[i]) begin
            for (int k = 0; k < 3; k++) begin
                make_issue(branch_ops[i], it);
                it.rs1_data  = pair_a[k];
                it.operand_b = pair_b[k];
                send(it);
            end
        end
        make_issue(JAL, it);
        send(it);
        make_issue(JAL, it);
        it.imm_target = it.imm_target | 32'h2;   // Halfword target traps
        send(it);
        make_issue(JALR, it);
        it.rs1_data  = 32'h0000_1000;
        it.operand_b = 32'd9;
        send(it);
        make_issue(JALR, it);
        it.rs1_data  = 32'h0000_1000;
        it.operand_b = 32'd6;
        send(it);

        // Every size at every byte offset
        foreach (mem_ops[i]) begin
            for (int off = 0; off < 4; off++) begin
                make_issue(mem_ops[i], it);
                it.rs1_data  = it.rs1_data & 32'hffff_fff0;
                it.operand_b = off;
                send(it);
            end
        end

        foreach (csr_ops[i]) begin
            for (int k = 0; k < 4; k++) begin
                make_issue(csr_ops[i], it);
                it.rd  = k[0] ? 5'd0 : 5'd5;
                it.rs1 = k[1] ? 5'd0 : 5'd3;
                send(it);
            end
        end
        make_issue(CSRRW, it);
        it.csr_addr = 12'hc00;   // Read-only cycle counter
        send(it);
        privilege = USER;
        make_issue(CSRRS, it);
        send(it);

        make_issue(ECALL, it);
        send(it);
        privilege = SUPERVISOR;
        make_issue(ECALL, it);
        send(it);
        privilege = MACHINE;
        make_issue(ECALL, it);
        send(it);
        make_issue(EBREAK, it);
        send(it);
        make_issue(MRET, it);
        send(it);

        // Credits run out with none returned
        make_issue(ADD, it);
        present(it);
        accepts = 0;
        for (int i = 0; i < 10; i++) begin
            was_ready = issue_ready;
            next_cycle();
            if (was_ready) begin
                accepts++;
                make_issue(ADD, it);
                present(it);
            end
        end
        assert (accepts == `EXEC_CREDITS && !issue_ready)
            else fail_run($sformatf("error: %0t: %0d accepts without credit return",
                                    $time, accepts));

        for (int i = 0; i < `EXEC_CREDITS; i++) begin
            credit_return = 1'b1;
            next_cycle();
            credit_return = 1'b0;
            assert (issue_ready)
                else fail_run("issue_ready_o did not rise after a credit return");
            next_cycle();
            assert (!issue_ready)
                else fail_run("issue_ready_o stayed high after one accept");
            make_issue(ADD, it);
            present(it);
        end

        // Drain back to a full counter
        issue.valid = 1'b0;
        for (int i = 0; i < `EXEC_CREDITS; i++) begin
            credit_return = 1'b1;
            next_cycle();
        end
        credit_return = 1'b0;
        repeat (2) next_cycle();

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* verilog/exec_alu.sv */
`timescale 1ns/1ps

module exec_alu
    import exec_isa_pkg::*;
    import exec_if_pkg::*;
(
    input  issue_t   issue_i,
    output alu_res_t alu_o
);

    logic [31:0] opa;
    logic [31:0] opb;
    logic [4:0]  shamt;

    assign opa   = issue_i.rs1_data;
    assign opb   = issue_i.operand_b;
    assign shamt = opb[4:0];

    // Adder also serves address and JALR target
    always_comb begin
        if (issue_i.op == SUB) begin
            alu_o.sum = opa + (~opb + 32'd1);
        end else begin
            alu_o.sum = opa + opb;
        end
    end

    always_comb begin
        unique case (issue_i.op)
            AND:     alu_o.logic_shift = opa & opb;
            OR:      alu_o.logic_shift = opa | opb;
            XOR:     alu_o.logic_shift = opa ^ opb;
            SLL:     alu_o.logic_shift = opa << shamt;
            SRL:     alu_o.logic_shift = opa >> shamt;
            SRA:     alu_o.logic_shift = $unsigned($signed(opa) >>> shamt);
            default: alu_o.logic_shift = '0;
        endcase
    end

    // Compare flags for branches and SLT
    assign alu_o.eq  = (opa == opb);
    assign alu_o.lt  = ($signed(opa) < $signed(opb));
    assign alu_o.ltu = (opa < opb);

endmodule

/* verilog/exec_branch.sv */
`timescale 1ns/1ps

`include "exec_params.svh"

module exec_branch
    import exec_isa_pkg::*;
    import exec_if_pkg::*;
(
    input  issue_t           issue_i,
    input  alu_res_t         alu_i,
    output logic             jump_o,
    output logic [`XLEN-1:0] target_o,
    output logic             target_misaligned_o
);

    // Taken decision
    always_comb begin
        unique case (issue_i.op)
            BEQ:       jump_o = alu_i.eq;
            BNE:       jump_o = !alu_i.eq;
            BLT:       jump_o = alu_i.lt;
            BGE:       jump_o = !alu_i.lt;
            BLTU:      jump_o = alu_i.ltu;
            BGEU:      jump_o = !alu_i.ltu;
            JAL, JALR: jump_o = 1'b1;
            default:   jump_o = 1'b0;
        endcase
    end

    always_comb begin
        if (issue_i.op == JALR) begin
            target_o = {alu_i.sum[`XLEN-1:1], 1'b0};  // Register relative
        end else begin
            target_o = issue_i.imm_target;            // PC relative
        end
    end

    // No compressed support, so halfword targets trap
    assign target_misaligned_o = jump_o && target_o[1];

endmodule

/* verilog/exec_csr.sv */
`timescale 1ns/1ps

`include "exec_params.svh"

module exec_csr
    import exec_isa_pkg::*;
    import exec_if_pkg::*;
(
    input  issue_t   issue_i,
    input  logic     accept_i,
    input  priv_e    privilege_i,
    output csr_req_t csr_req_o,
    output logic     illegal_o
);

    logic    read_en;
    logic    write_en;
    csr_op_e op;
    logic    imm_form;

    always_comb begin
        read_en  = 1'b0;
        write_en = 1'b0;
        op       = NONE;
        unique case (issue_i.op)
            CSRRW, CSRRWI: begin
                read_en  = (issue_i.rd != '0);   // Skip the read side effect
                write_en = 1'b1;
                op       = WRITE;
            end
            CSRRS, CSRRSI: begin
                read_en  = 1'b1;
                write_en = (issue_i.rs1 != '0);
                op       = SET;
            end
            CSRRC, CSRRCI: begin
                read_en  = 1'b1;
                write_en = (issue_i.rs1 != '0);
                op       = CLEAR;
            end
            default: ;
        endcase
    end

    assign imm_form = issue_i.op inside {CSRRWI, CSRRSI, CSRRCI};

    // Read-only space or privilege above current mode
    assign illegal_o =
        (write_en && (issue_i.csr_addr[`CSR_RO_MSB:`CSR_RO_LSB] == 2'b11)) ||
        ((read_en || write_en) &&
         (issue_i.csr_addr[`CSR_PRIV_MSB:`CSR_PRIV_LSB] > privilege_i));

    always_comb begin
        csr_req_o = '0;
        if (accept_i && (op != NONE)) begin
            csr_req_o.read  = read_en && !illegal_o;
            csr_req_o.write = write_en && !illegal_o;
            csr_req_o.op    = op;
            csr_req_o.wdata = imm_form ? {{(`XLEN-`REG_ADDR_W){1'b0}}, issue_i.rs1}
                                       : issue_i.rs1_data;
        end
    end

endmodule

/* verilog/exec_if_pkg.sv */
package exec_if_pkg;

    `include "exec_params.svh"

    import exec_isa_pkg::*;

    typedef struct packed {
        logic                   valid;
        op_e                    op;
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data;
        logic [`XLEN-1:0]       operand_b;  // rs2 or immediate
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;        // Also the CSR immediate
        logic [`CSR_ADDR_W-1:0] csr_addr;
        logic [`XLEN-1:0]       pc_next;
        logic [`XLEN-1:0]       imm_target; // pc + imm
    } issue_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       addr;
        logic                   read;
        logic [`BYTE_LANES-1:0] byte_en;
        logic [`XLEN-1:0]       wdata;
    } mem_req_t;

    typedef struct packed {
        logic             read;
        logic             write;
        csr_op_e          op;
        logic [`XLEN-1:0] wdata;
    } csr_req_t;

    typedef struct packed {
        logic                   valid;
        op_e                    op;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       result;
        logic                   we;
    } retire_t;

    typedef struct packed {
        logic             jump;
        logic             ctx_switch;
        logic [`XLEN-1:0] target;
        logic             raise_exception;
        exc_code_e        exception_code;
        logic             mret;
    } redirect_t;

    typedef struct packed {
        logic [`XLEN-1:0] sum;
        logic [`XLEN-1:0] logic_shift;
        logic             eq;
        logic             lt;
        logic             ltu;
    } alu_res_t;

endpackage

/* verilog/exec_isa_pkg.sv */
package exec_isa_pkg;

    // Decoded operation from the issue stage
    typedef enum logic [5:0] {
        NOP,
        // Register and immediate arithmetic
        ADD, SUB, AND, OR, XOR,
        SLL, SRL, SRA,
        SLT, SLTU,
        LUI, AUIPC,
        // Control transfer
        JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        // Memory
        LB, LBU, LH, LHU, LW,
        SB, SH, SW,
        // CSR access
        CSRRW, CSRRS, CSRRC,
        CSRRWI, CSRRSI, CSRRCI,
        // System
        ECALL, EBREAK, MRET
    } op_e;

    typedef enum logic [1:0] {
        NONE,
        WRITE,
        SET,
        CLEAR
    } csr_op_e;

    typedef enum logic [1:0] {
        USER       = 2'd0,
        SUPERVISOR = 2'd1,
        MACHINE    = 2'd3
    } priv_e;

    // Standard mcause values for synchronous causes
    typedef enum logic [4:0] {
        INSTR_ADDR_MISALIGNED = 5'd0,
        ILLEGAL_INSTR         = 5'd2,
        BREAKPOINT            = 5'd3,
        LOAD_ADDR_MISALIGNED  = 5'd4,
        STORE_ADDR_MISALIGNED = 5'd6,
        ECALL_FROM_UMODE      = 5'd8,
        ECALL_FROM_MMODE      = 5'd11,
        NE                    = 5'd31   // No exception
    } exc_code_e;

endpackage

/* verilog/exec_lsu.sv */
`timescale 1ns/1ps

`include "exec_params.svh"

module exec_lsu
    import exec_isa_pkg::*;
    import exec_if_pkg::*;
(
    input  issue_t   issue_i,
    input  alu_res_t alu_i,
    output mem_req_t mem_req_o,
    output logic     load_misaligned_o,
    output logic     store_misaligned_o
);

    logic [`XLEN-1:0]       addr;
    logic                   is_load;
    logic                   is_store;
    logic [`BYTE_LANES-1:0] byte_en;
    logic [`XLEN-1:0]       wdata;

    assign addr     = alu_i.sum;
    assign is_load  = issue_i.op inside {LB, LBU, LH, LHU, LW};
    assign is_store = issue_i.op inside {SB, SH, SW};

    // Lane select from size and offset
    always_comb begin
        unique case (issue_i.op)
            SB:      byte_en = {{(`BYTE_LANES-1){1'b0}}, 1'b1} << addr[1:0];
            SH:      byte_en = {{(`BYTE_LANES-2){1'b0}}, 2'b11} << addr[1:0];
            SW:      byte_en = '1;
            default: byte_en = '0;
        endcase
    end

    // Narrow stores replicated over the word
    always_comb begin
        unique case (issue_i.op)
            SB:      wdata = {`BYTE_LANES{issue_i.rs2_data[7:0]}};
            SH:      wdata = {(`BYTE_LANES/2){issue_i.rs2_data[15:0]}};
            default: wdata = issue_i.rs2_data;
        endcase
    end

    assign load_misaligned_o  = ((issue_i.op inside {LH, LHU}) && addr[0]) ||
                                ((issue_i.op == LW) && (addr[1:0] != 2'b00));
    assign store_misaligned_o = ((issue_i.op == SH) && addr[0]) ||
                                ((issue_i.op == SW) && (addr[1:0] != 2'b00));

    assign mem_req_o.valid   = is_load || is_store;
    assign mem_req_o.addr    = addr;
    assign mem_req_o.read    = is_load;
    assign mem_req_o.byte_en = byte_en;
    assign mem_req_o.wdata   = wdata;

endmodule

/* verilog/exec_params.svh */
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Datapath widths
`define XLEN          32
`define REG_ADDR_W    5
`define CSR_ADDR_W    12
`define BYTE_LANES    4

// Retire side flow control
`define EXEC_CREDITS  4
`define CREDIT_CNT_W  3

// CSR address fields
`define CSR_RO_MSB    11
`define CSR_RO_LSB    10
`define CSR_PRIV_MSB  9
`define CSR_PRIV_LSB  8

`endif

/* verilog/exec_retire.sv */
`timescale 1ns/1ps

`include "exec_params.svh"

module exec_retire
    import exec_isa_pkg::*;
    import exec_if_pkg::*;
(
    input  logic             clk,
    input  logic             reset_n,
    input  issue_t           issue_i,
    input  alu_res_t         alu_i,
    input  logic [`XLEN-1:0] csr_rdata_i,
    input  mem_req_t         mem_req_i,
    input  logic             raise_exception_i,
    input  logic             credit_return_i,
    output logic             issue_ready_o,
    output logic             accept_o,
    output retire_t          retire_o,
    output mem_req_t         mem_req_o
);

    logic [`CREDIT_CNT_W-1:0] credit_cnt;
    logic [`XLEN-1:0]         result;
    logic                     writes_rd;
    retire_t                  retire_d;
    retire_t                  retire_q;
    mem_req_t                 mem_q;
    logic                     retire_vld_q;
    logic                     mem_vld_q;

    //////////////////////////////
    // Result select
    //////////////////////////////

    always_comb begin
        unique case (issue_i.op)
            CSRRW, CSRRS, CSRRC,
            CSRRWI, CSRRSI, CSRRCI:        result = csr_rdata_i;
            JAL, JALR:                     result = issue_i.pc_next;   // Link value
            LUI:                           result = issue_i.operand_b;
            AUIPC:                         result = issue_i.imm_target;
            SLT:                           result = {{(`XLEN-1){1'b0}}, alu_i.lt};
            SLTU:                          result = {{(`XLEN-1){1'b0}}, alu_i.ltu};
            AND, OR, XOR, SLL, SRL, SRA:   result = alu_i.logic_shift;
            default:                       result = alu_i.sum;
        endcase
    end

    assign writes_rd = !(issue_i.op inside {NOP, SB, SH, SW, BEQ, BNE, BLT, BGE, BLTU, BGEU});

    always_comb begin
        retire_d.valid  = 1'b1;
        retire_d.op     = issue_i.op;
        retire_d.rd     = issue_i.rd;
        retire_d.result = result;
        retire_d.we     = writes_rd && (issue_i.rd != '0) && !raise_exception_i;
    end

    //////////////////////////////
    // Credits
    //////////////////////////////

    assign issue_ready_o = (credit_cnt != '0);
    assign accept_o      = issue_i.valid && issue_ready_o;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            credit_cnt <= `CREDIT_CNT_W'(`EXEC_CREDITS);
        end else if (accept_o && !credit_return_i) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!accept_o && credit_return_i) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // Output registers
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            retire_vld_q <= 1'b0;
            mem_vld_q    <= 1'b0;
        end else begin
            retire_vld_q <= accept_o;
            mem_vld_q    <= accept_o && mem_req_i.valid && !raise_exception_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_o) begin
            retire_q <= retire_d;
            mem_q    <= mem_req_i;
        end
    end

    always_comb begin
        retire_o        = retire_q;
        retire_o.valid  = retire_vld_q;
        mem_req_o       = mem_q;
        mem_req_o.valid = mem_vld_q;
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        credit_cnt <= `CREDIT_CNT_W'(`EXEC_CREDITS))
        else $error("exec_retire: credit count above limit");

    assert property (@(posedge clk) disable iff (!reset_n)
        (credit_cnt == `CREDIT_CNT_W'(`EXEC_CREDITS)) |-> !credit_return_i)
        else $error("exec_retire: credit returned while counter full");

endmodule

/* verilog/exec_stage.sv */
`timescale 1ns/1ps

`include "exec_params.svh"

module exec_stage
    import exec_isa_pkg::*;
    import exec_if_pkg::*;
(
    input  logic             clk,
    input  logic             reset_n,
    input  issue_t           issue_i,
    output logic             issue_ready_o,
    input  priv_e            privilege_i,
    input  logic [`XLEN-1:0] mtvec_i,
    input  logic [`XLEN-1:0] mepc_i,
    input  logic [`XLEN-1:0] csr_rdata_i,
    output csr_req_t         csr_req_o,
    input  logic             credit_return_i,
    output mem_req_t         mem_req_o,
    output retire_t          retire_o,
    output redirect_t        redirect_o
);

    alu_res_t         alu_res;
    mem_req_t         mem_req;
    logic             jump;
    logic [`XLEN-1:0] jump_target;
    logic             target_misaligned;
    logic             load_misaligned;
    logic             store_misaligned;
    logic             csr_illegal;
    logic             accept;

    //////////////////////////////
    // Combinational units
    //////////////////////////////

    exec_alu exec_alu_i (
        .issue_i (issue_i),
        .alu_o   (alu_res)
    );

    exec_branch exec_branch_i (
        .issue_i             (issue_i),
        .alu_i               (alu_res),
        .jump_o              (jump),
        .target_o            (jump_target),
        .target_misaligned_o (target_misaligned)
    );

    exec_lsu exec_lsu_i (
        .issue_i            (issue_i),
        .alu_i              (alu_res),
        .mem_req_o          (mem_req),
        .load_misaligned_o  (load_misaligned),
        .store_misaligned_o (store_misaligned)
    );

    exec_csr exec_csr_i (
        .issue_i     (issue_i),
        .accept_i    (accept),
        .privilege_i (privilege_i),
        .csr_req_o   (csr_req_o),
        .illegal_o   (csr_illegal)
    );

    exec_trap exec_trap_i (
        .issue_i             (issue_i),
        .accept_i            (accept),
        .privilege_i         (privilege_i),
        .mtvec_i             (mtvec_i),
        .mepc_i              (mepc_i),
        .jump_i              (jump),
        .target_i            (jump_target),
        .target_misaligned_i (target_misaligned),
        .load_misaligned_i   (load_misaligned),
        .store_misaligned_i  (store_misaligned),
        .csr_illegal_i       (csr_illegal),
        .redirect_o          (redirect_o)
    );

    //////////////////////////////
    // Retire and credits
    //////////////////////////////

    exec_retire exec_retire_i (
        .clk               (clk),
        .reset_n           (reset_n),
        .issue_i           (issue_i),
        .alu_i             (alu_res),
        .csr_rdata_i       (csr_rdata_i),
        .mem_req_i         (mem_req),
        .raise_exception_i (redirect_o.raise_exception),
        .credit_return_i   (credit_return_i),
        .issue_ready_o     (issue_ready_o),
        .accept_o          (accept),
        .retire_o          (retire_o),
        .mem_req_o         (mem_req_o)
    );

endmodule

/* verilog/exec_trap.sv */
`timescale 1ns/1ps

`include "exec_params.svh"

module exec_trap
    import exec_isa_pkg::*;
    import exec_if_pkg::*;
(
    input  issue_t           issue_i,
    input  logic             accept_i,
    input  priv_e            privilege_i,
    input  logic [`XLEN-1:0] mtvec_i,
    input  logic [`XLEN-1:0] mepc_i,
    input  logic             jump_i,
    input  logic [`XLEN-1:0] target_i,
    input  logic             target_misaligned_i,
    input  logic             load_misaligned_i,
    input  logic             store_misaligned_i,
    input  logic             csr_illegal_i,
    output redirect_t        redirect_o
);

    exc_code_e exc_code;
    logic      raise;
    logic      mret;

    // Highest priority cause wins
    always_comb begin
        if (csr_illegal_i)
            exc_code = ILLEGAL_INSTR;
        else if (target_misaligned_i)
            exc_code = INSTR_ADDR_MISALIGNED;
        else if (issue_i.op == ECALL)
            exc_code = (privilege_i == USER) ? ECALL_FROM_UMODE : ECALL_FROM_MMODE;
        else if (issue_i.op == EBREAK)
            exc_code = BREAKPOINT;
        else if (load_misaligned_i)
            exc_code = LOAD_ADDR_MISALIGNED;
        else if (store_misaligned_i)
            exc_code = STORE_ADDR_MISALIGNED;
        else
            exc_code = NE;
    end

    assign raise = accept_i && (exc_code != NE);
    assign mret  = accept_i && (issue_i.op == MRET) && !raise;

    always_comb begin
        redirect_o = '0;
        if (accept_i) begin
            redirect_o.raise_exception = raise;
            redirect_o.exception_code  = exc_code;
            redirect_o.mret            = mret;
            redirect_o.ctx_switch      = raise || mret;
            redirect_o.jump            = jump_i && !raise;   // Trap overrides the jump
            if (raise || mret)
                redirect_o.target = mret ? mepc_i : mtvec_i;
            else if (jump_i)
                redirect_o.target = target_i;
        end
    end

    always_comb begin
        assert (!(redirect_o.jump && redirect_o.ctx_switch))
            else $error("exec_trap: jump and context switch together");
    end

endmodule
